// ==== common/udp_echo_pkg.sv ====
package udp_echo_pkg;

    // Payload bus width and its byte enables
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // Header field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // One payload beat as it sits in the payload FIFO
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [KEEP_W-1:0] tkeep;
        logic              tlast;
        logic              tuser;
    } beat_t;

    // Reply header for the transmit side
    // Constant IP fields are filled in by the stack further down
    typedef struct packed {
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } reply_hdr_t;

    // Per-frame decision
    typedef enum logic {
        VERDICT_DROP = 1'b0,
        VERDICT_ECHO = 1'b1
    } verdict_t;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    output logic full,
    input  logic pop,
    output T     pop_data,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // Wrap at DEPTH so non power-of-two depths work
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Callers must honour full and empty
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    );

endmodule

// ==== echo/echo_port_decode.sv ====
`timescale 1ns/1ps

module echo_port_decode
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT     = 16'd1234,
    parameter int        VERDICT_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,
    input  ip_addr_t   rx_source_ip,
    input  udp_port_t  rx_source_port,
    input  udp_port_t  rx_dest_port,
    input  udp_len_t   rx_length,
    output logic       rply_valid,
    output reply_hdr_t rply_hdr,
    input  logic       rply_ready,
    output logic       verdict_valid,
    output verdict_t   verdict,
    input  logic       verdict_pop
);

    logic     port_match;
    logic     hdr_fire;
    logic     vq_full;
    logic     vq_empty;
    verdict_t vq_in;

    // The one place the echo port is tested
    assign port_match = (rx_dest_port == ECHO_PORT);

    // Echo headers also need room in the reply register
    assign rx_hdr_ready = !vq_full && (rply_ready || !port_match);
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;

    assign rply_valid = rx_hdr_valid && port_match && !vq_full;

    // Reply goes back to the sender with the ports swapped
    assign rply_hdr.dest_ip     = rx_source_ip;
    assign rply_hdr.source_port = rx_dest_port;
    assign rply_hdr.dest_port   = rx_source_port;
    assign rply_hdr.length      = rx_length;

    assign vq_in         = port_match ? VERDICT_ECHO : VERDICT_DROP;
    assign verdict_valid = !vq_empty;

    // Pushed once per accepted header and popped at the frame's last beat
    sync_fifo #(
        .T     (verdict_t),
        .DEPTH (VERDICT_DEPTH)
    ) i_verdict_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (hdr_fire),
        .push_data (vq_in),
        .full      (vq_full),
        .pop       (verdict_pop),
        .pop_data  (verdict),
        .empty     (vq_empty)
    );

    a_reply_only_on_match: assert property (
        @(posedge clk) disable iff (rst) rply_valid |-> rply_hdr.source_port == ECHO_PORT
    );

endmodule

// ==== echo/echo_payload_gate.sv ====
`timescale 1ns/1ps

module echo_payload_gate
    import udp_echo_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] rx_payload_tdata,
    input  logic [KEEP_W-1:0] rx_payload_tkeep,
    input  logic              rx_payload_tvalid,
    input  logic              rx_payload_tlast,
    input  logic              rx_payload_tuser,
    output logic              rx_payload_tready,
    input  logic              verdict_valid,
    input  verdict_t          verdict,
    output logic              verdict_pop,
    output logic [DATA_W-1:0] tx_payload_tdata,
    output logic [KEEP_W-1:0] tx_payload_tkeep,
    output logic              tx_payload_tvalid,
    output logic              tx_payload_tlast,
    output logic              tx_payload_tuser,
    input  logic              tx_payload_tready
);

    beat_t rx_beat;
    beat_t tx_beat;
    logic  echo_frame;
    logic  rx_fire;
    logic  fifo_push;
    logic  fifo_pop;
    logic  fifo_full;
    logic  fifo_empty;

    assign rx_beat = '{
        tdata: rx_payload_tdata,
        tkeep: rx_payload_tkeep,
        tlast: rx_payload_tlast,
        tuser: rx_payload_tuser
    };

    assign echo_frame = (verdict == VERDICT_ECHO);

    // Stall until the frame's verdict is known; drop frames sink at full rate
    assign rx_payload_tready = verdict_valid && (!echo_frame || !fifo_full);
    assign rx_fire           = rx_payload_tvalid && rx_payload_tready;
    assign fifo_push         = rx_fire && echo_frame;
    assign verdict_pop       = rx_fire && rx_payload_tlast;

    sync_fifo #(
        .T     (beat_t),
        .DEPTH (PAYLOAD_DEPTH)
    ) i_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (fifo_push),
        .push_data (rx_beat),
        .full      (fifo_full),
        .pop       (fifo_pop),
        .pop_data  (tx_beat),
        .empty     (fifo_empty)
    );

    assign tx_payload_tvalid = !fifo_empty;
    assign fifo_pop          = tx_payload_tvalid && tx_payload_tready;
    assign tx_payload_tdata  = tx_beat.tdata;
    assign tx_payload_tkeep  = tx_beat.tkeep;
    assign tx_payload_tlast  = tx_beat.tlast;
    assign tx_payload_tuser  = tx_beat.tuser;

    a_beat_has_verdict: assert property (
        @(posedge clk) disable iff (rst) rx_fire |-> verdict_valid
    );

    // Head verdict must hold steady in decode until this side pops it
    a_verdict_held: assert property (
        @(posedge clk) disable iff (rst)
        verdict_valid && !verdict_pop |=> verdict_valid && $stable(verdict)
    );

endmodule

// ==== echo/echo_reply_build.sv ====
`timescale 1ns/1ps

module echo_reply_build
    import udp_echo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rply_valid,
    input  reply_hdr_t        rply_hdr,
    output logic              rply_ready,
    output logic              tx_hdr_valid,
    output ip_addr_t          tx_dest_ip,
    output udp_port_t         tx_source_port,
    output udp_port_t         tx_dest_port,
    output udp_len_t          tx_length,
    input  logic              tx_hdr_ready,
    input  logic [DATA_W-1:0] tx_payload_tdata,
    input  logic              tx_payload_tvalid,
    input  logic              tx_payload_tready,
    input  logic              tx_payload_tlast,
    output logic [7:0]        led
);

    reply_hdr_t hdr_q;
    logic       hdr_valid_q;
    logic       first_beat;
    logic       tx_fire;

    // Takes a new header when empty or draining this cycle
    assign rply_ready = !hdr_valid_q || tx_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_q <= 1'b0;
        end else if (rply_ready) begin
            hdr_valid_q <= rply_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rply_valid && rply_ready) begin
            hdr_q <= rply_hdr;
        end
    end

    assign tx_hdr_valid   = hdr_valid_q;
    assign tx_dest_ip     = hdr_q.dest_ip;
    assign tx_source_port = hdr_q.source_port;
    assign tx_dest_port   = hdr_q.dest_port;
    assign tx_length      = hdr_q.length;

    assign tx_fire = tx_payload_tvalid && tx_payload_tready;

    // First byte of every sent frame goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'h00;
        end else if (tx_fire) begin
            first_beat <= tx_payload_tlast;
            if (first_beat) begin
                led <= tx_payload_tdata[7:0];
            end
        end
    end

    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=>
            tx_hdr_valid && $stable(tx_dest_ip) && $stable(tx_source_port)
            && $stable(tx_dest_port) && $stable(tx_length)
    );

endmodule

// ==== echo/udp_echo_core.sv ====
`timescale 1ns/1ps

module udp_echo_core
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT     = 16'd1234,
    parameter int        PAYLOAD_DEPTH = 64,
    parameter int        VERDICT_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    // Receive side from the UDP stack
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  ip_addr_t          rx_source_ip,
    input  udp_port_t         rx_source_port,
    input  udp_port_t         rx_dest_port,
    input  udp_len_t          rx_length,
    input  logic [DATA_W-1:0] rx_payload_tdata,
    input  logic [KEEP_W-1:0] rx_payload_tkeep,
    input  logic              rx_payload_tvalid,
    input  logic              rx_payload_tlast,
    input  logic              rx_payload_tuser,
    output logic              rx_payload_tready,
    // Transmit side to the UDP stack
    output logic              tx_hdr_valid,
    output ip_addr_t          tx_dest_ip,
    output udp_port_t         tx_source_port,
    output udp_port_t         tx_dest_port,
    output udp_len_t          tx_length,
    input  logic              tx_hdr_ready,
    output logic [DATA_W-1:0] tx_payload_tdata,
    output logic [KEEP_W-1:0] tx_payload_tkeep,
    output logic              tx_payload_tvalid,
    output logic              tx_payload_tlast,
    output logic              tx_payload_tuser,
    input  logic              tx_payload_tready,
    output logic [7:0]        led
);

    logic       rply_valid;
    logic       rply_ready;
    reply_hdr_t rply_hdr;
    logic       verdict_valid;
    verdict_t   verdict;
    logic       verdict_pop;

    echo_port_decode #(
        .ECHO_PORT     (ECHO_PORT),
        .VERDICT_DEPTH (VERDICT_DEPTH)
    ) i_decode (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_source_ip   (rx_source_ip),
        .rx_source_port (rx_source_port),
        .rx_dest_port   (rx_dest_port),
        .rx_length      (rx_length),
        .rply_valid     (rply_valid),
        .rply_hdr       (rply_hdr),
        .rply_ready     (rply_ready),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict),
        .verdict_pop    (verdict_pop)
    );

    echo_payload_gate #(
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
    ) i_gate (
        .clk               (clk),
        .rst               (rst),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .rx_payload_tready (rx_payload_tready),
        .verdict_valid     (verdict_valid),
        .verdict           (verdict),
        .verdict_pop       (verdict_pop),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .tx_payload_tready (tx_payload_tready)
    );

    echo_reply_build i_reply (
        .clk               (clk),
        .rst               (rst),
        .rply_valid        (rply_valid),
        .rply_hdr          (rply_hdr),
        .rply_ready        (rply_ready),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_dest_ip        (tx_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .led               (led)
    );

endmodule

// ==== dv/udp_echo_tb.sv ====
`timescale 1ns/1ps

module udp_echo_tb
    import udp_echo_pkg::*;
;

    localparam udp_port_t ECHO_PORT      = 16'd1234;
    localparam int        PAYLOAD_DEPTH  = 64;
    localparam int        VERDICT_DEPTH  = 4;
    localparam int        NUM_FRAMES     = 200;
    localparam int        MAX_BEATS      = 8;
    localparam int        RESET_CYCLES   = 10;
    localparam int        DRIVE_DELAY    = 2;
    localparam int        TIMEOUT_CYCLES = NUM_FRAMES * MAX_BEATS * 20;
    localparam int        DRAIN_CYCLES   = PAYLOAD_DEPTH * 20;
    localparam int        SEED           = 32'h4c9e_ae61;

    logic              clk;
    logic              rst;
    logic              rx_hdr_valid;
    logic              rx_hdr_ready;
    ip_addr_t          rx_source_ip;
    udp_port_t         rx_source_port;
    udp_port_t         rx_dest_port;
    udp_len_t          rx_length;
    logic [DATA_W-1:0] rx_payload_tdata;
    logic [KEEP_W-1:0] rx_payload_tkeep;
    logic              rx_payload_tvalid;
    logic              rx_payload_tlast;
    logic              rx_payload_tuser;
    logic              rx_payload_tready;
    logic              tx_hdr_valid;
    ip_addr_t          tx_dest_ip;
    udp_port_t         tx_source_port;
    udp_port_t         tx_dest_port;
    udp_len_t          tx_length;
    logic              tx_hdr_ready;
    logic [DATA_W-1:0] tx_payload_tdata;
    logic [KEEP_W-1:0] tx_payload_tkeep;
    logic              tx_payload_tvalid;
    logic              tx_payload_tlast;
    logic              tx_payload_tuser;
    logic              tx_payload_tready;
    logic [7:0]        led;

    // Pre-generated frames
    ip_addr_t  f_src_ip   [NUM_FRAMES];
    udp_port_t f_src_port [NUM_FRAMES];
    udp_port_t f_dst_port [NUM_FRAMES];
    udp_len_t  f_len      [NUM_FRAMES];
    int        f_beats    [NUM_FRAMES];
    int        f_hdr_gap  [NUM_FRAMES];
    beat_t     f_beat     [NUM_FRAMES * MAX_BEATS];
    int        f_beat_gap [NUM_FRAMES * MAX_BEATS];

    // Reference model queues hold echo frames only
    reply_hdr_t exp_hdr_q[$];
    beat_t      exp_beat_q[$];
    logic       expect_first = 1'b1;
    logic       led_pending  = 1'b0;
    logic [7:0] led_expected = 8'h00;

    udp_echo_core #(
        .ECHO_PORT     (ECHO_PORT),
        .PAYLOAD_DEPTH (PAYLOAD_DEPTH),
        .VERDICT_DEPTH (VERDICT_DEPTH)
    ) i_dut (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_source_ip      (rx_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .rx_payload_tready (rx_payload_tready),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_dest_ip        (tx_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .tx_payload_tready (tx_payload_tready),
        .led               (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            stop_with_fail();
        end
    endtask

    task automatic build_frames();
        int        n;
        udp_port_t port;
        beat_t     b;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            port = ECHO_PORT;
            if ($urandom_range(0, 1) == 0) begin
                while (port == ECHO_PORT) begin
                    port = udp_port_t'($urandom());
                end
            end
            n             = $urandom_range(1, MAX_BEATS);
            f_src_ip[i]   = ip_addr_t'($urandom());
            f_src_port[i] = udp_port_t'($urandom());
            f_dst_port[i] = port;
            f_len[i]      = udp_len_t'(8 + n * 8);
            f_beats[i]    = n;
            f_hdr_gap[i]  = $urandom_range(0, 3);
            // Expected reply goes back to the sender with the ports swapped
            if (port == ECHO_PORT) begin
                exp_hdr_q.push_back('{dest_ip: f_src_ip[i], source_port: port,
                                      dest_port: f_src_port[i], length: f_len[i]});
            end
            for (int k = 0; k < n; k++) begin
                b.tdata = {$urandom(), $urandom()};
                b.tkeep = KEEP_W'($urandom());
                b.tlast = (k == n - 1);
                b.tuser = 1'($urandom());
                f_beat[i * MAX_BEATS + k]     = b;
                f_beat_gap[i * MAX_BEATS + k] = $urandom_range(0, 2);
                if (port == ECHO_PORT) begin
                    exp_beat_q.push_back(b);
                end
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    task automatic send_header(input int i);
        logic accepted;
        rx_hdr_valid   = 1'b1;
        rx_source_ip   = f_src_ip[i];
        rx_source_port = f_src_port[i];
        rx_dest_port   = f_dst_port[i];
        rx_length      = f_len[i];
        accepted       = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = rx_hdr_ready;
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input beat_t b);
        logic accepted;
        rx_payload_tvalid = 1'b1;
        rx_payload_tdata  = b.tdata;
        rx_payload_tkeep  = b.tkeep;
        rx_payload_tlast  = b.tlast;
        rx_payload_tuser  = b.tuser;
        accepted          = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = rx_payload_tready;
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        rx_payload_tvalid = 1'b0;
    endtask

    task automatic drive_headers();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            idle_cycles(f_hdr_gap[i]);
            send_header(i);
        end
    endtask

    // Drop frames go through here too and must be fully consumed
    task automatic drive_payloads();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            for (int k = 0; k < f_beats[i]; k++) begin
                idle_cycles(f_beat_gap[i * MAX_BEATS + k]);
                send_beat(f_beat[i * MAX_BEATS + k]);
            end
        end
    endtask

    task automatic toggle_tx_ready();
        forever begin
            @(posedge clk);
            #(DRIVE_DELAY);
            tx_hdr_ready      = ($urandom_range(0, 2) != 0);
            tx_payload_tready = ($urandom_range(0, 2) != 0);
        end
    endtask

    // Handshakes seen at the falling edge complete at the next rising edge
    always @(negedge clk) begin
        reply_hdr_t eh;
        beat_t      eb;
        if (!rst) begin
            if (led_pending) begin
                check_value("led after first beat", led_expected, led);
                led_pending = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("Reply header sent with no echo frame waiting for it");
                    stop_with_fail();
                end
                eh = exp_hdr_q.pop_front();
                check_value("tx_dest_ip", eh.dest_ip, tx_dest_ip);
                check_value("tx_source_port", eh.source_port, tx_source_port);
                check_value("tx_dest_port", eh.dest_port, tx_dest_port);
                check_value("tx_length", eh.length, tx_length);
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                if (exp_beat_q.size() == 0) begin
                    $display("Payload beat sent with no echo beat waiting for it");
                    stop_with_fail();
                end
                eb = exp_beat_q.pop_front();
                check_value("tx_payload_tdata", eb.tdata, tx_payload_tdata);
                check_value("tx_payload_tkeep", eb.tkeep, tx_payload_tkeep);
                check_value("tx_payload_tlast", eb.tlast, tx_payload_tlast);
                check_value("tx_payload_tuser", eb.tuser, tx_payload_tuser);
                if (expect_first) begin
                    led_pending  = 1'b1;
                    led_expected = eb.tdata[7:0];
                end
                expect_first = eb.tlast;
            end
        end
    end

    // Generous bound of 20 cycles per possible beat
    initial begin
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired: the run did not finish and the DUT seems to hang");
        stop_with_fail();
    end

    initial begin
        int drain;
        rst               = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_source_ip      = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        tx_hdr_ready      = 1'b0;
        tx_payload_tready = 1'b0;
        void'($urandom(SEED));
        build_frames();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        // Idle state straight out of reset
        @(negedge clk);
        check_value("tx_hdr_valid after reset", 1'b0, tx_hdr_valid);
        check_value("tx_payload_tvalid after reset", 1'b0, tx_payload_tvalid);
        check_value("rx_payload_tready after reset", 1'b0, rx_payload_tready);
        check_value("led after reset", 8'h00, led);
        @(posedge clk);
        #(DRIVE_DELAY);

        fork
            toggle_tx_ready();
        join_none
        fork
            drive_headers();
            drive_payloads();
        join

        // Room for a full payload FIFO to drain under back-pressure
        drain = 0;
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0)
               && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        // Quiet period catches stray headers or beats
        repeat (20) @(posedge clk);

        if (exp_hdr_q.size() == 0 && exp_beat_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Expected replies still outstanding at the end of the run");
            stop_with_fail();
        end
    end

endmodule

// ==== verilog.f ====
common/udp_echo_pkg.sv
src/sync_fifo.sv
echo/echo_port_decode.sv
echo/echo_payload_gate.sv
echo/echo_reply_build.sv
echo/udp_echo_core.sv
dv/udp_echo_tb.sv

// ==== Bender.yml ====
package:
  name: udp_echo

sources:
  - files:
      - common/udp_echo_pkg.sv
      - src/sync_fifo.sv
      - echo/echo_port_decode.sv
      - echo/echo_payload_gate.sv
      - echo/echo_reply_build.sv
      - echo/udp_echo_core.sv
  - target: test
    files:
      - dv/udp_echo_tb.sv
